// File: filelist.f
+incdir+src
src/mwae_pkg.sv
src/error_report_select.sv
src/error_capture_fsm.sv
src/error_log_regs.sv
src/mwae_error_logger.sv
verification/tb_mwae_error_logger.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_mwae_error_logger

output="$(./obj_dir/Vtb_mwae_error_logger)"
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Test OK"; then
  exit 0
else
  exit 1
fi

// File: verification/tb_mwae_error_logger.sv
// Error logger testbench
`timescale 1ns/1ns
`include "mwae_consts.svh"

module tb_mwae_error_logger;

  localparam int ITERATIONS     = 40;
  localparam int TIMEOUT_CYCLES = 6 * ITERATIONS * 40;
  localparam int PULSE_WINDOW   = 10;

  logic                    clk;
  logic                    reset_n;
  mwae_pkg::alg_1a_error_t alg_1a;
  mwae_pkg::alg_1b_error_t alg_1b;
  logic                    busy;
  logic                    set_to_busy;
  logic                    self_check_en;
  logic                    force_disable;
  logic                    sw_status;
  logic                    slverr_wr;
  logic                    slverr_rd;
  logic                    poison_rd;
  mwae_pkg::error_log_t    log_q;
  logic                    record_error;

  logic [31:0] lfsr_state;
  string       test_name;
  int          error_count;
  int          errors_at_start;
  int          tests_run;
  int          tests_passed;
  int          cycle_count;

  mwae_error_logger u_dut (
    .clk             (clk),
    .reset_n         (reset_n),
    .i_alg_1a        (alg_1a),
    .i_alg_1b        (alg_1b),
    .i_busy          (busy),
    .i_set_to_busy   (set_to_busy),
    .i_self_check_en (self_check_en),
    .i_force_disable (force_disable),
    .i_sw_status     (sw_status),
    .i_slverr_wr     (slverr_wr),
    .i_slverr_rd     (slverr_rd),
    .i_poison_rd     (poison_rd),
    .o_log           (log_q),
    .o_record_error  (record_error)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic next_bit();
    logic feedback;
    feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], feedback};
    return feedback;
  endfunction

  // Fills every field of both reports, flags included, one LFSR step per bit
  task automatic randomize_reports();
    for (int i = 0; i < $bits(alg_1a); i++)
    begin
      alg_1a[i] = next_bit();
    end
    for (int i = 0; i < $bits(alg_1b); i++)
    begin
      alg_1b[i] = next_bit();
    end
  endtask

  // Expected log after a capture where 1a wins and its offset is padded with zeros
  function automatic mwae_pkg::error_log_t model_log(input mwae_pkg::alg_1a_error_t a,
                                                     input mwae_pkg::alg_1b_error_t b);
    mwae_pkg::error_log_t exp;
    exp              = '0;
    exp.error_status = 1'b1;
    if (a.found)
    begin
      exp.observed_pattern  = a.observed_pattern;
      exp.expected_pattern  = a.expected_pattern;
      exp.loop_number       = a.loop_number;
      exp.byte_offset[`MWAE_OFFSET_1A_WIDTH-1:0] = a.byte_offset;
      exp.set_number        = a.set_number;
      exp.address_increment = a.address_increment;
      exp.address           = a.address;
    end
    else
    begin
      exp.observed_pattern  = b.observed_pattern;
      exp.expected_pattern  = b.expected_pattern;
      exp.loop_number       = b.loop_number;
      exp.byte_offset       = b.byte_offset;
      exp.set_number        = b.set_number;
      exp.address_increment = b.address_increment;
      exp.address           = b.address;
    end
    return exp;
  endfunction

  task automatic check_log(input mwae_pkg::error_log_t exp);
    assert (log_q == exp)
    else
    begin
      $display("[FAIL] %s: o_log expected %h actual %h", test_name, exp, log_q);
      error_count++;
    end
  endtask

  task automatic expect_no_pulse(input string when);
    assert (!record_error)
    else
    begin
      $display("%s: o_record_error pulsed %s", test_name, when);
      error_count++;
    end
  endtask

  // Waits for the record pulse after the report was driven on this falling edge
  task automatic capture_report(input mwae_pkg::error_log_t exp);
    int latency;
    @(negedge clk);
    latency = 1;
    while (!record_error && latency < PULSE_WINDOW)
    begin
      @(negedge clk);
      latency++;
    end
    assert (record_error)
    else
    begin
      $display("%s: no record pulse within %0d cycles", test_name, PULSE_WINDOW);
      error_count++;
    end
    if (record_error)
    begin
      assert (latency == 2)
      else
      begin
        $display("[FAIL] %s: pulse latency expected 2 actual %0d", test_name, latency);
        error_count++;
      end
      check_log(exp);
      // The algorithm drops its report and software sees the status bit
      alg_1a.found = 1'b0;
      alg_1b.found = 1'b0;
      sw_status    = 1'b1;
      @(negedge clk);
      expect_no_pulse("for more than one cycle");
    end
  endtask

  // Software clears the status bit, after which the FSM is idle again in two cycles
  task automatic acknowledge();
    sw_status = 1'b0;
    @(negedge clk);
    check_log('0);
    @(negedge clk);
  endtask

  // Raises one of the three bus error inputs for a single cycle
  task automatic pulse_bus_error(input int k);
    slverr_wr = (k == 0);
    slverr_rd = (k == 1);
    poison_rd = (k == 2);
    @(negedge clk);
    slverr_wr = 1'b0;
    slverr_rd = 1'b0;
    poison_rd = 1'b0;
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = error_count;
  endtask

  task automatic end_test();
    int errors;
    errors = error_count - errors_at_start;
    tests_run++;
    if (errors == 0)
    begin
      tests_passed++;
    end
    $display("%-14s %s (%0d errors)", test_name, (errors == 0) ? "pass" : "fail", errors);
  endtask

  task automatic arbitrate_both();
    begin_test("arbitration");
    for (int n = 0; n < ITERATIONS; n++)
    begin
      randomize_reports();
      alg_1a.found = 1'b1;
      alg_1b.found = 1'b1;
      capture_report(model_log(alg_1a, alg_1b));
      acknowledge();
    end
    end_test();
  endtask

  task automatic log_alg_1b_only();
    begin_test("alg_1b_only");
    for (int n = 0; n < ITERATIONS; n++)
    begin
      randomize_reports();
      alg_1a.found = 1'b0;
      alg_1b.found = 1'b1;
      capture_report(model_log(alg_1a, alg_1b));
      acknowledge();
    end
    end_test();
  endtask

  task automatic gate_reports();
    begin_test("gating");
    for (int n = 0; n < ITERATIONS; n++)
    begin
      randomize_reports();
      alg_1a.found = 1'b1;
      if (next_bit())
      begin
        busy = 1'b0;
      end
      else
      begin
        self_check_en = 1'b0;
      end
      repeat (PULSE_WINDOW)
      begin
        @(negedge clk);
        expect_no_pulse("while gated");
        check_log('0);
      end
      alg_1a.found  = 1'b0;
      alg_1b.found  = 1'b0;
      busy          = 1'b1;
      self_check_en = 1'b1;
    end
    end_test();
  endtask

  task automatic hold_and_rearm();
    mwae_pkg::error_log_t held;
    begin_test("hold_rearm");
    for (int n = 0; n < ITERATIONS; n++)
    begin
      randomize_reports();
      alg_1a.found = 1'b1;
      held         = model_log(alg_1a, alg_1b);
      capture_report(held);
      // New miscompares while software has not acknowledged are dropped
      repeat (5)
      begin
        randomize_reports();
        alg_1b.found = 1'b1;
        @(negedge clk);
        expect_no_pulse("while waiting for software");
        check_log(held);
      end
      alg_1a.found = 1'b0;
      alg_1b.found = 1'b0;
      acknowledge();
      randomize_reports();
      alg_1b.found = 1'b1;
      capture_report(model_log(alg_1a, alg_1b));
      acknowledge();
    end
    end_test();
  endtask

  task automatic log_bus_errors();
    mwae_pkg::error_log_t status_only;
    mwae_pkg::error_log_t exp;
    begin_test("bus_errors");
    status_only              = '0;
    status_only.error_status = 1'b1;
    for (int n = 0; n < ITERATIONS; n++)
    begin
      for (int k = 0; k < 3; k++)
      begin
        pulse_bus_error(k);
        check_log(status_only);
        expect_no_pulse("after a bus error");
        // On top of a captured report the pattern, set, increment and address survive
        randomize_reports();
        alg_1a.found = 1'b1;
        exp          = model_log(alg_1a, alg_1b);
        capture_report(exp);
        force_disable = 1'b1;
        @(negedge clk);
        force_disable = 1'b0;
        sw_status     = 1'b0;
        pulse_bus_error(k);
        exp.loop_number = '0;
        exp.byte_offset = '0;
        check_log(exp);
        expect_no_pulse("after a bus error");
        set_to_busy = 1'b1;
        @(negedge clk);
        set_to_busy = 1'b0;
        check_log('0);
      end
    end
    end_test();
  endtask

  task automatic force_disable_in_wait();
    mwae_pkg::error_log_t kept;
    begin_test("force_disable");
    for (int n = 0; n < ITERATIONS; n++)
    begin
      randomize_reports();
      if (!alg_1a.found && !alg_1b.found)
      begin
        alg_1b.found = 1'b1;
      end
      kept = model_log(alg_1a, alg_1b);
      capture_report(kept);
      force_disable = 1'b1;
      @(negedge clk);
      force_disable = 1'b0;
      check_log(kept);
      expect_no_pulse("on a forced disable");
      randomize_reports();
      alg_1a.found = 1'b1;
      capture_report(model_log(alg_1a, alg_1b));
      acknowledge();
    end
    end_test();
  endtask

  // Ends the run if the tests stall
  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  initial
  begin
    lfsr_state    = 32'hcdad_f547;
    error_count   = 0;
    tests_run     = 0;
    tests_passed  = 0;
    test_name     = "reset";
    reset_n       = 1'b0;
    alg_1a        = '0;
    alg_1b        = '0;
    busy          = 1'b1;
    set_to_busy   = 1'b0;
    self_check_en = 1'b1;
    force_disable = 1'b0;
    sw_status     = 1'b0;
    slverr_wr     = 1'b0;
    slverr_rd     = 1'b0;
    poison_rd     = 1'b0;
    repeat (10) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);
    check_log('0);
    expect_no_pulse("after reset");

    arbitrate_both();
    log_alg_1b_only();
    gate_reports();
    hold_and_rearm();
    log_bus_errors();
    force_disable_in_wait();

    $display("%0d of %0d tests passed, %0d errors", tests_passed, tests_run, error_count);
    if (error_count == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: src/mwae_error_logger.sv
// Memory walk error logger top
`timescale 1ns/1ns

module mwae_error_logger (
  input  logic                    clk,
  input  logic                    reset_n,
  input  mwae_pkg::alg_1a_error_t i_alg_1a,
  input  mwae_pkg::alg_1b_error_t i_alg_1b,
  input  logic                    i_busy,
  input  logic                    i_set_to_busy,
  input  logic                    i_self_check_en,
  input  logic                    i_force_disable,
  input  logic                    i_sw_status,
  input  logic                    i_slverr_wr,
  input  logic                    i_slverr_rd,
  input  logic                    i_poison_rd,
  output mwae_pkg::error_log_t    o_log,
  output logic                    o_record_error
);

  mwae_pkg::err_report_t report;
  logic                  record;
  logic                  clear;

  // Pick one gated report from the two algorithms
  error_report_select u_select (
    .i_alg_1a        (i_alg_1a),
    .i_alg_1b        (i_alg_1b),
    .i_busy          (i_busy),
    .i_self_check_en (i_self_check_en),
    .o_report        (report)
  );

  error_capture_fsm u_fsm (
    .clk             (clk),
    .reset_n         (reset_n),
    .i_force_disable (i_force_disable),
    .i_report_valid  (report.valid),
    .i_sw_status     (i_sw_status),
    .o_record        (record),
    .o_clear         (clear),
    .o_record_error  (o_record_error)
  );

  error_log_regs u_log (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_set_to_busy (i_set_to_busy),
    .i_clear       (clear),
    .i_record      (record),
    .i_report      (report),
    .i_slverr_wr   (i_slverr_wr),
    .i_slverr_rd   (i_slverr_rd),
    .i_poison_rd   (i_poison_rd),
    .o_log         (o_log)
  );

endmodule

// File: src/error_log_regs.sv
// Error log register bank
`timescale 1ns/1ns

module error_log_regs (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  i_set_to_busy,
  input  logic                  i_clear,
  input  logic                  i_record,
  input  mwae_pkg::err_report_t i_report,
  input  logic                  i_slverr_wr,
  input  logic                  i_slverr_rd,
  input  logic                  i_poison_rd,
  output mwae_pkg::error_log_t  o_log
);

  logic clear_log;
  logic bus_error;

  // A new run and a software acknowledge both wipe the log
  assign clear_log = i_set_to_busy | i_clear;
  assign bus_error = i_slverr_wr | i_slverr_rd | i_poison_rd;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      o_log <= '0;
    end
    else if (clear_log)
    begin
      o_log <= '0;
    end
    else if (i_record)
    begin
      o_log.observed_pattern  <= i_report.observed_pattern;
      o_log.expected_pattern  <= i_report.expected_pattern;
      o_log.error_status      <= 1'b1;
      o_log.loop_number       <= i_report.loop_number;
      o_log.byte_offset       <= i_report.byte_offset;
      o_log.set_number        <= i_report.set_number;
      o_log.address_increment <= i_report.address_increment;
      o_log.address           <= i_report.address;
    end
    else if (bus_error)
    begin
      // Bus errors carry no detail, so only status, loop and offset change
      o_log.error_status <= 1'b1;
      o_log.loop_number  <= '0;
      o_log.byte_offset  <= '0;
    end
  end

endmodule

// File: src/error_capture_fsm.sv
// Error capture state machine
`timescale 1ns/1ns

module error_capture_fsm (
  input  logic clk,
  input  logic reset_n,
  input  logic i_force_disable,
  input  logic i_report_valid,
  input  logic i_sw_status,
  output logic o_record,
  output logic o_clear,
  output logic o_record_error
);

  mwae_pkg::capture_state_e state;
  mwae_pkg::capture_state_e next_state;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state <= mwae_pkg::IDLE;
    end
    else if (i_force_disable)
    begin
      // Abandon the capture but leave the log alone
      state <= mwae_pkg::IDLE;
    end
    else
    begin
      state <= next_state;
    end
  end

  always_comb
  begin
    next_state     = state;
    o_record       = 1'b0;
    o_clear        = 1'b0;
    o_record_error = 1'b0;

    case (state)
      mwae_pkg::IDLE:
      begin
        if (i_report_valid)
        begin
          next_state = mwae_pkg::RECORD;
        end
      end

      mwae_pkg::RECORD:
      begin
        // Log bank loads the report at the end of this cycle
        o_record   = 1'b1;
        next_state = mwae_pkg::SEND;
      end

      mwae_pkg::SEND:
      begin
        // One cycle pulse; the algorithm may release its report after it
        o_record_error = 1'b1;
        next_state     = mwae_pkg::WAIT;
      end

      mwae_pkg::WAIT:
      begin
        // Software acknowledges by dropping the status bit
        if (!i_sw_status)
        begin
          o_clear    = 1'b1;
          next_state = mwae_pkg::COMPLETE;
        end
      end

      mwae_pkg::COMPLETE:
      begin
        next_state = mwae_pkg::IDLE;
      end

      default:
      begin
        next_state = mwae_pkg::IDLE;
      end
    endcase
  end

endmodule

// File: src/error_report_select.sv
// Algorithm report arbiter
`timescale 1ns/1ns
`include "mwae_consts.svh"

module error_report_select (
  input  mwae_pkg::alg_1a_error_t i_alg_1a,
  input  mwae_pkg::alg_1b_error_t i_alg_1b,
  input  logic                    i_busy,
  input  logic                    i_self_check_en,
  output mwae_pkg::err_report_t   o_report
);

  // Zero bits that pad the 1a offset up to the logged width
  localparam int OFFSET_PAD = `MWAE_OFFSET_WIDTH - `MWAE_OFFSET_1A_WIDTH;

  logic any_found;

  assign any_found = i_alg_1a.found | i_alg_1b.found;

  always_comb
  begin
    // A miscompare counts only during a self-checked run
    o_report.valid = any_found & i_busy & i_self_check_en;

    // Algorithm 1a wins when both flag in the same cycle
    if (i_alg_1a.found)
    begin
      o_report.observed_pattern  = i_alg_1a.observed_pattern;
      o_report.expected_pattern  = i_alg_1a.expected_pattern;
      o_report.loop_number       = i_alg_1a.loop_number;
      o_report.byte_offset       = {{OFFSET_PAD{1'b0}}, i_alg_1a.byte_offset};
      o_report.set_number        = i_alg_1a.set_number;
      o_report.address_increment = i_alg_1a.address_increment;
      o_report.address           = i_alg_1a.address;
    end
    else
    begin
      o_report.observed_pattern  = i_alg_1b.observed_pattern;
      o_report.expected_pattern  = i_alg_1b.expected_pattern;
      o_report.loop_number       = i_alg_1b.loop_number;
      o_report.byte_offset       = i_alg_1b.byte_offset;
      o_report.set_number        = i_alg_1b.set_number;
      o_report.address_increment = i_alg_1b.address_increment;
      o_report.address           = i_alg_1b.address;
    end
  end

endmodule

// File: src/mwae_pkg.sv
// Memory walk error logger types
`include "mwae_consts.svh"

package mwae_pkg;

  // Miscompare report from algorithm 1a
  typedef struct packed {
    logic                              found;
    logic [`MWAE_PATTERN_WIDTH-1:0]    observed_pattern;
    logic [`MWAE_PATTERN_WIDTH-1:0]    expected_pattern;
    logic [`MWAE_LOOP_WIDTH-1:0]       loop_number;
    logic [`MWAE_OFFSET_1A_WIDTH-1:0]  byte_offset;
    logic [`MWAE_SET_WIDTH-1:0]        set_number;
    logic [`MWAE_INCR_WIDTH-1:0]       address_increment;
    logic [`MWAE_ADDR_WIDTH-1:0]       address;
  } alg_1a_error_t;

  // Miscompare report from algorithm 1b, with the full offset
  typedef struct packed {
    logic                              found;
    logic [`MWAE_PATTERN_WIDTH-1:0]    observed_pattern;
    logic [`MWAE_PATTERN_WIDTH-1:0]    expected_pattern;
    logic [`MWAE_LOOP_WIDTH-1:0]       loop_number;
    logic [`MWAE_OFFSET_WIDTH-1:0]     byte_offset;
    logic [`MWAE_SET_WIDTH-1:0]        set_number;
    logic [`MWAE_INCR_WIDTH-1:0]       address_increment;
    logic [`MWAE_ADDR_WIDTH-1:0]       address;
  } alg_1b_error_t;

  // Unified report after arbitration and gating
  typedef struct packed {
    logic                              valid;
    logic [`MWAE_PATTERN_WIDTH-1:0]    observed_pattern;
    logic [`MWAE_PATTERN_WIDTH-1:0]    expected_pattern;
    logic [`MWAE_LOOP_WIDTH-1:0]       loop_number;
    logic [`MWAE_OFFSET_WIDTH-1:0]     byte_offset;
    logic [`MWAE_SET_WIDTH-1:0]        set_number;
    logic [`MWAE_INCR_WIDTH-1:0]       address_increment;
    logic [`MWAE_ADDR_WIDTH-1:0]       address;
  } err_report_t;

  // Software visible error log
  typedef struct packed {
    logic [`MWAE_PATTERN_WIDTH-1:0]    observed_pattern;
    logic [`MWAE_PATTERN_WIDTH-1:0]    expected_pattern;
    logic                              error_status;
    logic [`MWAE_LOOP_WIDTH-1:0]       loop_number;
    logic [`MWAE_OFFSET_WIDTH-1:0]     byte_offset;
    logic [`MWAE_SET_WIDTH-1:0]        set_number;
    logic [`MWAE_INCR_WIDTH-1:0]       address_increment;
    logic [`MWAE_ADDR_WIDTH-1:0]       address;
  } error_log_t;

  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    RECORD   = 3'd1,
    SEND     = 3'd2,
    WAIT     = 3'd3,
    COMPLETE = 3'd4
  } capture_state_e;

endpackage

// File: src/mwae_consts.svh
// Memory walk error logger widths
`ifndef MWAE_CONSTS_SVH
`define MWAE_CONSTS_SVH

// Observed and expected data patterns
`define MWAE_PATTERN_WIDTH 32

// Address of the first failing access
`define MWAE_ADDR_WIDTH 64

// Loop counter of the walk
`define MWAE_LOOP_WIDTH 8

// Byte offset as it is held in the log
`define MWAE_OFFSET_WIDTH 8

// Algorithm 1a reports a narrower offset
`define MWAE_OFFSET_1A_WIDTH 6

`define MWAE_SET_WIDTH 4
`define MWAE_INCR_WIDTH 8

`endif
